//--- vgaPkg.sv
`default_nettype none

package vgaPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Pixel format
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0] rgbT; // Red 7:5, green 4:2, blue 1:0

	localparam int coordWidth = 10; // Wide enough for any counter value of the 640x480 frame
	localparam int spriteSize = 64;

	// ~~~~~~~~~~~~~~~~~~~~
	// 640x480 at 60 Hz
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int defaultHVisible = 640;
	localparam int defaultHFront = 16;
	localparam int defaultHSyncLen = 96;
	localparam int defaultHBack = 48;

	localparam int defaultVVisible = 480;
	localparam int defaultVFront = 10;
	localparam int defaultVSyncLen = 2;
	localparam int defaultVBack = 33;

endpackage

`default_nettype wire

//--- cpuBusPkg.sv
`default_nettype none

package cpuBusPkg;

	localparam int instrWidth = 18;
	localparam int wordWidth = 16;
	localparam int regCount = 16;

	// The register-form store has its opcode in 15:12 and its extension in 7:4
	localparam logic [3:0] storeOpcode = 4'b0100;
	localparam logic [3:0] storeExt = 4'b0100;

	localparam logic [1:0] displayRegion = 2'b11; // Data address bits 15:14

	// ~~~~~~~~~~~~~~~~~~~~
	// Register offsets, data address bits 2:0
	// ~~~~~~~~~~~~~~~~~~~~

	localparam logic [2:0] regHLocation = 3'd0;
	localparam logic [2:0] regVLocation = 3'd1;
	localparam logic [2:0] regBlank = 3'd2;
	localparam logic [2:0] regBgColor = 3'd3;
	localparam logic [2:0] regSpriteOn = 3'd4;
	localparam logic [2:0] regSpriteWhite = 3'd5;
	localparam logic [2:0] regTextColor = 3'd6;

endpackage

`default_nettype wire

//--- scanTiming.sv
`default_nettype none

module scanTiming #(
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int hFront = vgaPkg::defaultHFront,
	parameter int hSyncLen = vgaPkg::defaultHSyncLen,
	parameter int hBack = vgaPkg::defaultHBack,
	parameter int vVisible = vgaPkg::defaultVVisible,
	parameter int vFront = vgaPkg::defaultVFront,
	parameter int vSyncLen = vgaPkg::defaultVSyncLen,
	parameter int vBack = vgaPkg::defaultVBack,
	parameter int framesPerBlink = 30
) (
	input wire CLK,
	input wire rstN,
	output logic [vgaPkg::coordWidth-1:0] hPix,
	output logic [vgaPkg::coordWidth-1:0] vPix,
	output logic visible,
	output logic hSyncLvl,
	output logic vSyncLvl,
	output logic lights
);
	import vgaPkg::*;

	localparam int hTotal = hVisible + hFront + hSyncLen + hBack;
	localparam int vTotal = vVisible + vFront + vSyncLen + vBack;

	localparam logic [coordWidth-1:0] hLast = coordWidth'(hTotal - 1);
	localparam logic [coordWidth-1:0] vLast = coordWidth'(vTotal - 1);
	localparam logic [coordWidth-1:0] hVisEnd = coordWidth'(hVisible);
	localparam logic [coordWidth-1:0] vVisEnd = coordWidth'(vVisible);
	localparam logic [coordWidth-1:0] hSyncFirst = coordWidth'(hVisible + hFront);
	localparam logic [coordWidth-1:0] hSyncEnd = coordWidth'(hVisible + hFront + hSyncLen);
	localparam logic [coordWidth-1:0] vSyncFirst = coordWidth'(vVisible + vFront);
	localparam logic [coordWidth-1:0] vSyncEnd = coordWidth'(vVisible + vFront + vSyncLen);

	localparam int frameBits = (framesPerBlink > 1) ? $clog2(framesPerBlink) : 1;
	localparam logic [frameBits-1:0] frameLast = frameBits'(framesPerBlink - 1);

	logic [1:0] prescale;
	logic pixelTick;
	logic lineEnd;
	logic frameEnd;
	logic [frameBits-1:0] frameCount;

	assign pixelTick = (prescale == 2'd3); // One pixel per four system clocks
	assign lineEnd = pixelTick && (hPix == hLast);
	assign frameEnd = lineEnd && (vPix == vLast);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			prescale <= 2'd0;
		end else begin
			prescale <= prescale + 2'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Scan counters
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			hPix <= '0;
			vPix <= '0;
		end else if (pixelTick) begin
			hPix <= lineEnd ? '0 : hPix + 1'b1;
			if (lineEnd) begin
				vPix <= frameEnd ? '0 : vPix + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			frameCount <= '0;
			lights <= 1'b0;
		end else if (frameEnd) begin
			if (frameCount == frameLast) begin
				frameCount <= '0;
				lights <= ~lights; // Heartbeat
			end else begin
				frameCount <= frameCount + 1'b1;
			end
		end
	end

	assign visible = (hPix < hVisEnd) && (vPix < vVisEnd);
	assign hSyncLvl = !((hPix >= hSyncFirst) && (hPix < hSyncEnd)); // Negative polarity
	assign vSyncLvl = !((vPix >= vSyncFirst) && (vPix < vSyncEnd));

endmodule

`default_nettype wire

//--- displayRegs.sv
`default_nettype none

module displayRegs (
	input wire CLK,
	input wire rstN,
	input wire [cpuBusPkg::instrWidth-1:0] inst,
	input wire [cpuBusPkg::wordWidth-1:0] dataAddr,
	input wire [cpuBusPkg::wordWidth-1:0] dataIn,
	output vgaPkg::rgbT bgColor,
	output vgaPkg::rgbT textColor,
	output logic blank,
	output logic spriteOn,
	output logic spriteWhite,
	output logic [vgaPkg::coordWidth-1:0] hLocation,
	output logic [vgaPkg::coordWidth-1:0] vLocation
);
	import vgaPkg::*;
	import cpuBusPkg::*;

	logic isStore;
	logic storeHit;

	assign isStore = (inst[15:12] == storeOpcode) && (inst[7:4] == storeExt);
	assign storeHit = isStore && (dataAddr[15:14] == displayRegion);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			bgColor <= 8'h00;
			textColor <= 8'hFF;
			blank <= 1'b0;
			spriteOn <= 1'b1; // Sprite shows from power-up
			spriteWhite <= 1'b0;
			hLocation <= '0;
			vLocation <= '0;
		end else if (storeHit) begin
			case (dataAddr[2:0])
				regHLocation: begin
					hLocation <= dataIn[coordWidth-1:0];
				end
				regVLocation: begin
					vLocation <= dataIn[coordWidth-1:0];
				end
				regBlank: begin
					blank <= dataIn[0];
				end
				regBgColor: begin
					bgColor <= dataIn[7:0];
				end
				regSpriteOn: begin
					spriteOn <= dataIn[0];
				end
				regSpriteWhite: begin
					spriteWhite <= dataIn[0];
				end
				regTextColor: begin
					textColor <= dataIn[7:0];
				end
				default: begin
				end // Offset 7 is unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

//--- spriteGen.sv
`default_nettype none

module spriteGen (
	input wire [$clog2(vgaPkg::spriteSize)-1:0] sprX,
	input wire [$clog2(vgaPkg::spriteSize)-1:0] sprY,
	output vgaPkg::rgbT spriteColor,
	output logic alpha
);
	import vgaPkg::*;

	localparam int sprBits = $clog2(spriteSize);
	localparam logic [sprBits-1:0] holeFirst = sprBits'(spriteSize / 4);
	localparam logic [sprBits-1:0] holeLast = sprBits'(3 * spriteSize / 4 - 1);

	logic inHoleX;
	logic inHoleY;

	assign inHoleX = (sprX >= holeFirst) && (sprX <= holeLast);
	assign inHoleY = (sprY >= holeFirst) && (sprY <= holeLast);

	// The frame is opaque and the middle half on both axes lets the background through
	assign alpha = !(inHoleX && inHoleY);

	assign spriteColor = {sprX[5:3], sprY[5:3], sprX[2:1]}; // Gradient tile

endmodule

`default_nettype wire

//--- registerView.sv
`default_nettype none

module registerView #(
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int vVisible = vgaPkg::defaultVVisible
) (
	input wire [vgaPkg::coordWidth-1:0] hPix,
	input wire [vgaPkg::coordWidth-1:0] vPix,
	input wire DEBUG,
	input wire [cpuBusPkg::regCount*cpuBusPkg::wordWidth-1:0] regValues,
	input wire vgaPkg::rgbT bgColor,
	input wire vgaPkg::rgbT textColor,
	input wire blank,
	output vgaPkg::rgbT bgPixel
);
	import vgaPkg::*;
	import cpuBusPkg::*;

	localparam int cellWidth = hVisible / wordWidth;
	localparam int rowHeight = vVisible / regCount;
	localparam int regBits = $clog2(regCount);
	localparam int bitBits = $clog2(wordWidth);

	logic [coordWidth-1:0] rowSel;
	logic [coordWidth-1:0] colSel;
	logic [regBits-1:0] regIdx;
	logic [bitBits-1:0] bitIdx;
	logic inGrid;
	logic [wordWidth-1:0] regWord;
	logic cellBit;

	// ~~~~~~~~~~~~~~~~~~~~
	// Bit-cell grid
	// ~~~~~~~~~~~~~~~~~~~~

	assign rowSel = vPix / coordWidth'(rowHeight);
	assign colSel = hPix / coordWidth'(cellWidth);
	assign inGrid = (rowSel < regCount) && (colSel < wordWidth);

	assign regIdx = rowSel[regBits-1:0];
	assign bitIdx = ~colSel[bitBits-1:0]; // Leftmost cell is the MSB

	assign regWord = regValues[regIdx*wordWidth +: wordWidth];
	assign cellBit = inGrid && regWord[bitIdx];

	always_comb begin
		if (DEBUG) begin
			bgPixel = cellBit ? textColor : bgColor;
		end else if (blank) begin
			bgPixel = '0;
		end else begin
			bgPixel = bgColor;
		end
	end

endmodule

`default_nettype wire

//--- pixelMixer.sv
`default_nettype none

module pixelMixer (
	input wire CLK,
	input wire rstN,
	input wire [vgaPkg::coordWidth-1:0] hPix,
	input wire [vgaPkg::coordWidth-1:0] vPix,
	input wire visible,
	input wire hSyncLvl,
	input wire vSyncLvl,
	input wire DEBUG,
	input wire [vgaPkg::coordWidth-1:0] hLocation,
	input wire [vgaPkg::coordWidth-1:0] vLocation,
	input wire spriteOn,
	input wire spriteWhite,
	input wire vgaPkg::rgbT bgPixel,
	input wire vgaPkg::rgbT spriteColor,
	input wire alpha,
	output logic [$clog2(vgaPkg::spriteSize)-1:0] sprX,
	output logic [$clog2(vgaPkg::spriteSize)-1:0] sprY,
	output vgaPkg::rgbT RGB,
	output logic HSync,
	output logic VSync
);
	import vgaPkg::*;

	localparam int sprBits = $clog2(spriteSize);

	logic [coordWidth-1:0] hOffset;
	logic [coordWidth-1:0] vOffset;
	logic spriteHit;
	rgbT pixel;

	// Offset is only meaningful once the position is at or past the location
	assign hOffset = hPix - hLocation;
	assign vOffset = vPix - vLocation;
	assign sprX = hOffset[sprBits-1:0];
	assign sprY = vOffset[sprBits-1:0];

	assign spriteHit = (hPix >= hLocation) && (hOffset < spriteSize)
		&& (vPix >= vLocation) && (vOffset < spriteSize)
		&& (hPix > 0) && (vPix > 0);

	always_comb begin
		if (spriteHit && !DEBUG && spriteOn) begin
			if (spriteWhite) begin
				pixel = 8'hFF;
			end else if (alpha) begin
				pixel = spriteColor;
			end else begin
				pixel = bgPixel;
			end
		end else begin
			pixel = bgPixel;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			RGB <= '0;
			HSync <= 1'b1;
			VSync <= 1'b1;
		end else begin
			RGB <= visible ? pixel : '0; // Black in the blanking intervals
			HSync <= hSyncLvl;
			VSync <= vSyncLvl;
		end
	end

endmodule

`default_nettype wire

//--- vgaController.sv
`default_nettype none

module vgaController #(
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int hFront = vgaPkg::defaultHFront,
	parameter int hSyncLen = vgaPkg::defaultHSyncLen,
	parameter int hBack = vgaPkg::defaultHBack,
	parameter int vVisible = vgaPkg::defaultVVisible,
	parameter int vFront = vgaPkg::defaultVFront,
	parameter int vSyncLen = vgaPkg::defaultVSyncLen,
	parameter int vBack = vgaPkg::defaultVBack,
	parameter int framesPerBlink = 30
) (
	input wire CLK,
	input wire rstN,
	input wire DEBUG,
	input wire [cpuBusPkg::instrWidth-1:0] inst,
	input wire [cpuBusPkg::regCount*cpuBusPkg::wordWidth-1:0] regValues,
	input wire [cpuBusPkg::wordWidth-1:0] dataAddr,
	input wire [cpuBusPkg::wordWidth-1:0] dataIn,
	output vgaPkg::rgbT RGB,
	output logic HSync,
	output logic VSync,
	output logic lights
);
	import vgaPkg::*;

	localparam int sprBits = $clog2(spriteSize);

	logic [coordWidth-1:0] hPix;
	logic [coordWidth-1:0] vPix;
	logic visible;
	logic hSyncLvl;
	logic vSyncLvl;

	rgbT bgColor;
	rgbT textColor;
	logic blank;
	logic spriteOn;
	logic spriteWhite;
	logic [coordWidth-1:0] hLocation;
	logic [coordWidth-1:0] vLocation;

	logic [sprBits-1:0] sprX;
	logic [sprBits-1:0] sprY;
	rgbT spriteColor;
	logic alpha;
	rgbT bgPixel;

	// ~~~~~~~~~~~~~~~~~~~~
	// Timing and CPU side
	// ~~~~~~~~~~~~~~~~~~~~

	scanTiming #(
		.hVisible(hVisible),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vVisible(vVisible),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack),
		.framesPerBlink(framesPerBlink)
	) uScanTiming (
		.CLK(CLK),
		.rstN(rstN),
		.hPix(hPix),
		.vPix(vPix),
		.visible(visible),
		.hSyncLvl(hSyncLvl),
		.vSyncLvl(vSyncLvl),
		.lights(lights)
	);

	displayRegs uDisplayRegs (
		.CLK(CLK),
		.rstN(rstN),
		.inst(inst),
		.dataAddr(dataAddr),
		.dataIn(dataIn),
		.bgColor(bgColor),
		.textColor(textColor),
		.blank(blank),
		.spriteOn(spriteOn),
		.spriteWhite(spriteWhite),
		.hLocation(hLocation),
		.vLocation(vLocation)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Pixel path
	// ~~~~~~~~~~~~~~~~~~~~

	spriteGen uSpriteGen (
		.sprX(sprX),
		.sprY(sprY),
		.spriteColor(spriteColor),
		.alpha(alpha)
	);

	registerView #(
		.hVisible(hVisible),
		.vVisible(vVisible)
	) uRegisterView (
		.hPix(hPix),
		.vPix(vPix),
		.DEBUG(DEBUG),
		.regValues(regValues),
		.bgColor(bgColor),
		.textColor(textColor),
		.blank(blank),
		.bgPixel(bgPixel)
	);

	pixelMixer uPixelMixer (
		.CLK(CLK),
		.rstN(rstN),
		.hPix(hPix),
		.vPix(vPix),
		.visible(visible),
		.hSyncLvl(hSyncLvl),
		.vSyncLvl(vSyncLvl),
		.DEBUG(DEBUG),
		.hLocation(hLocation),
		.vLocation(vLocation),
		.spriteOn(spriteOn),
		.spriteWhite(spriteWhite),
		.bgPixel(bgPixel),
		.spriteColor(spriteColor),
		.alpha(alpha),
		.sprX(sprX),
		.sprY(sprY),
		.RGB(RGB),
		.HSync(HSync),
		.VSync(VSync)
	);

endmodule

`default_nettype wire

//--- tbVgaController.sv
`default_nettype none

module tbVgaController;
	import vgaPkg::*;
	import cpuBusPkg::*;

	// Small screen so that a whole frame runs quickly
	localparam int hVis = 160;
	localparam int hFr = 8;
	localparam int hSl = 16;
	localparam int hBk = 8;
	localparam int vVis = 128;
	localparam int vFr = 2;
	localparam int vSl = 2;
	localparam int vBk = 4;
	localparam int blinkFrames = 2;

	localparam int hTotal = hVis + hFr + hSl + hBk;
	localparam int vTotal = vVis + vFr + vSl + vBk;
	localparam int frameCycles = 4 * hTotal * vTotal; // One pixel every four clocks
	localparam int testFrames = 7;
	localparam int timeoutCycles = (testFrames + 1) * frameCycles; // One frame of slack

	logic CLK;
	logic rstN;
	logic DEBUG;
	logic [instrWidth-1:0] inst;
	logic [regCount*wordWidth-1:0] regValues;
	logic [wordWidth-1:0] dataAddr;
	logic [wordWidth-1:0] dataIn;
	rgbT RGB;
	logic HSync;
	logic VSync;
	logic lights;

	// Values driven at the next edge, and the values the DUT currently sees
	logic [instrWidth-1:0] nextInst = '0;
	logic [wordWidth-1:0] nextAddr = '0;
	logic [wordWidth-1:0] nextData = '0;
	logic nextTakes = 1'b0;
	logic nextDebug = 1'b0;
	logic [regCount*wordWidth-1:0] nextRegs = '0;
	logic [wordWidth-1:0] curAddr = '0;
	logic [wordWidth-1:0] curData = '0;
	logic curTakes = 1'b0;
	logic curDebug = 1'b0;
	logic [regCount*wordWidth-1:0] curRegs = '0;

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model state
	// ~~~~~~~~~~~~~~~~~~~~

	int mPre = 0;
	int mH = 0;
	int mV = 0;
	int mFrame = 0;
	logic mLights = 1'b0;
	rgbT mRGB = 8'h00;
	logic mHS = 1'b1;
	logic mVS = 1'b1;
	logic frameWrap = 1'b0;
	rgbT mBg = 8'h00;
	rgbT mText = 8'hFF;
	logic mBlank = 1'b0;
	logic mSprOn = 1'b1;
	logic mSprWhite = 1'b0;
	int mHLoc = 0;
	int mVLoc = 0;

	int cycleCount = 0;
	logic prevHS = 1'b1;
	logic prevVS = 1'b1;
	logic prevLights = 1'b0;
	int lastHFall = -1;
	int lastVFall = -1;
	int hWidth = 0;
	int hPeriod = 0;
	int vWidth = 0;
	int vPeriod = 0;
	int toggles[$];

	vgaController #(
		.hVisible(hVis),
		.hFront(hFr),
		.hSyncLen(hSl),
		.hBack(hBk),
		.vVisible(vVis),
		.vFront(vFr),
		.vSyncLen(vSl),
		.vBack(vBk),
		.framesPerBlink(blinkFrames)
	) dut (
		.CLK(CLK),
		.rstN(rstN),
		.DEBUG(DEBUG),
		.inst(inst),
		.regValues(regValues),
		.dataAddr(dataAddr),
		.dataIn(dataIn),
		.RGB(RGB),
		.HSync(HSync),
		.VSync(VSync),
		.lights(lights)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic abortRun(input string reason);
		$display(">>> FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkColor(input string what, input rgbT got, input rgbT want);
		if (got !== want) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
			abortRun("wrong colour on the display output");
		end
	endtask

	task automatic checkLevel(input string what, input logic got, input logic want);
		if (got !== want) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
			abortRun("wrong level on a single-bit output");
		end
	endtask

	task automatic expectCycles(input string what, input int got, input int want);
		if (got != want) begin
			$display("mismatch at %0t: %s is %0d cycles, expected %0d", $time, what, got, want);
			abortRun("wrong cycle count");
		end
	endtask

	// Debug cells or the background lie underneath and the sprite goes on top
	function automatic rgbT predictPixel(input int h, input int v);
		rgbT under;
		int row;
		int col;
		int sx;
		int sy;
		row = v / (vVis / regCount);
		col = h / (hVis / wordWidth);
		if (curDebug) begin
			under = curRegs[row * wordWidth + (wordWidth - 1) - col] ? mText : mBg;
		end else begin
			under = mBlank ? 8'h00 : mBg;
		end
		sx = h - mHLoc;
		sy = v - mVLoc;
		if (sx < 0 || sx >= spriteSize || sy < 0 || sy >= spriteSize || h == 0 || v == 0) begin
			return under;
		end
		if (curDebug || !mSprOn) begin
			return under;
		end
		if (mSprWhite) begin
			return 8'hFF;
		end
		if (sx >= 16 && sx <= 47 && sy >= 16 && sy <= 47) begin
			return under; // Transparent centre
		end
		return {3'(sx >> 3), 3'(sy >> 3), 2'(sx >> 1)};
	endfunction

	task automatic advanceModel;
		mRGB = (mH < hVis && mV < vVis) ? predictPixel(mH, mV) : 8'h00;
		mHS = !(mH >= hVis + hFr && mH < hVis + hFr + hSl);
		mVS = !(mV >= vVis + vFr && mV < vVis + vFr + vSl);
		if (curTakes) begin
			case (curAddr[2:0])
				regHLocation: mHLoc = int'(curData[9:0]);
				regVLocation: mVLoc = int'(curData[9:0]);
				regBlank: mBlank = curData[0];
				regBgColor: mBg = curData[7:0];
				regSpriteOn: mSprOn = curData[0];
				regSpriteWhite: mSprWhite = curData[0];
				regTextColor: mText = curData[7:0];
				default: ;
			endcase
		end
		frameWrap = 1'b0;
		if (mPre == 3) begin
			if (mH == hTotal - 1) begin
				mH = 0;
				if (mV == vTotal - 1) begin
					mV = 0;
					frameWrap = 1'b1;
					mFrame++;
					if (mFrame == blinkFrames) begin
						mFrame = 0;
						mLights = !mLights;
					end
				end else begin
					mV++;
				end
			end else begin
				mH++;
			end
		end
		mPre = (mPre + 1) % 4;
	endtask

	task automatic trackEdges;
		if (prevHS && !HSync) begin
			if (lastHFall >= 0) begin
				hPeriod = cycleCount - lastHFall;
			end
			lastHFall = cycleCount;
		end
		if (!prevHS && HSync && lastHFall >= 0) begin
			hWidth = cycleCount - lastHFall;
		end
		if (prevVS && !VSync) begin
			if (lastVFall >= 0) begin
				vPeriod = cycleCount - lastVFall;
			end
			lastVFall = cycleCount;
		end
		if (!prevVS && VSync && lastVFall >= 0) begin
			vWidth = cycleCount - lastVFall;
		end
		if (lights !== prevLights) begin
			toggles.push_back(cycleCount);
		end
		prevHS = HSync;
		prevVS = VSync;
		prevLights = lights;
	endtask

	// Models and drives one clock at the rising edge and compares at the falling edge
	task automatic stepCycle;
		@(posedge CLK);
		advanceModel();
		curAddr = nextAddr;
		curData = nextData;
		curTakes = nextTakes;
		curDebug = nextDebug;
		curRegs = nextRegs;
		inst <= nextInst;
		dataAddr <= nextAddr;
		dataIn <= nextData;
		DEBUG <= nextDebug;
		regValues <= nextRegs;
		cycleCount++;
		if (cycleCount > timeoutCycles) begin
			$display("timeout: the tests ran past %0d cycles without finishing", timeoutCycles);
			abortRun("timeout");
		end
		@(negedge CLK);
		checkColor("RGB", RGB, mRGB);
		checkLevel("HSync", HSync, mHS);
		checkLevel("VSync", VSync, mVS);
		checkLevel("lights", lights, mLights);
		trackEdges();
	endtask

	task automatic runFrame;
		do begin
			stepCycle();
		end while (!frameWrap);
	endtask

	function automatic logic [instrWidth-1:0] storeWord(input logic [3:0] op,
			input logic [3:0] ext);
		logic [instrWidth-1:0] w;
		w = instrWidth'($urandom);
		w[15:12] = op;
		w[7:4] = ext;
		return w;
	endfunction

	function automatic logic [wordWidth-1:0] displayAddr(input logic [1:0] region,
			input logic [2:0] offset);
		return {region, 11'($urandom), offset};
	endfunction

	// The store is on the bus for one clock and takes says whether it should land
	task automatic busWrite(input logic [instrWidth-1:0] word, input logic [wordWidth-1:0] addr,
			input logic [wordWidth-1:0] data, input logic takes);
		nextInst = word;
		nextAddr = addr;
		nextData = data;
		nextTakes = takes;
		stepCycle();
		nextInst = '0;
		nextTakes = 1'b0;
	endtask

	task automatic displayStore(input logic [2:0] offset, input logic [wordWidth-1:0] data);
		busWrite(storeWord(storeOpcode, storeExt), displayAddr(displayRegion, offset),
			data, 1'b1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic resetState;
		runFrame(); // Black except the power-up sprite in the corner
	endtask

	task automatic backgroundAndBlank;
		rgbT colour;
		colour = 8'($urandom);
		displayStore(regBgColor, {8'($urandom), colour});
		busWrite(storeWord(4'b0101, storeExt), displayAddr(displayRegion, regBgColor),
			16'($urandom), 1'b0);
		busWrite(storeWord(storeOpcode, 4'b0110), displayAddr(displayRegion, regBgColor),
			16'($urandom), 1'b0);
		busWrite(storeWord(storeOpcode, storeExt), displayAddr(2'b10, regBgColor),
			16'($urandom), 1'b0);
		runFrame();
		displayStore(regBlank, {15'($urandom), 1'b1});
		runFrame();
		displayStore(regBlank, {15'($urandom), 1'b0});
	endtask

	task automatic spriteOverlay;
		displayStore(regHLocation, {6'($urandom), 10'(1 + $urandom % 96)});
		displayStore(regVLocation, {6'($urandom), 10'(1 + $urandom % 64)});
		runFrame();
		displayStore(regSpriteWhite, 16'h0001);
		runFrame();
		displayStore(regSpriteWhite, 16'h0000);
		displayStore(regSpriteOn, 16'h0000);
		runFrame();
		displayStore(regSpriteOn, 16'h0001);
	endtask

	task automatic debugView;
		int i;
		displayStore(regTextColor, {8'($urandom), 8'($urandom)});
		displayStore(regBgColor, {8'($urandom), 8'($urandom)});
		for (i = 0; i < regCount * wordWidth / 32; i++) begin
			nextRegs[i * 32 +: 32] = $urandom;
		end
		nextDebug = 1'b1;
		runFrame(); // Sprite is still on and must not show
		nextDebug = 1'b0;
	endtask

	task automatic heartbeatAndSync;
		int i;
		repeat (4 * hTotal) stepCycle();
		expectCycles("HSync low width", hWidth, 4 * hSl);
		expectCycles("HSync period", hPeriod, 4 * hTotal);
		expectCycles("VSync low width", vWidth, 4 * hTotal * vSl);
		expectCycles("VSync period", vPeriod, frameCycles);
		expectCycles("lights toggle count", toggles.size(), testFrames / blinkFrames);
		expectCycles("first lights toggle", toggles[0], blinkFrames * frameCycles);
		for (i = 1; i < toggles.size(); i++) begin
			expectCycles("lights toggle interval", toggles[i] - toggles[i - 1],
				blinkFrames * frameCycles);
		end
	endtask

	initial begin
		void'($urandom(32'h6741da98));
		rstN = 1'b0;
		DEBUG = 1'b0;
		inst = '0;
		regValues = '0;
		dataAddr = '0;
		dataIn = '0;
		repeat (8) @(posedge CLK);
		rstN <= 1'b1;
		resetState();
		backgroundAndBlank();
		spriteOverlay();
		debugView();
		heartbeatAndSync();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
vgaPkg.sv
cpuBusPkg.sv
scanTiming.sv
displayRegs.sv
spriteGen.sv
registerView.sv
pixelMixer.sv
vgaController.sv
tbVgaController.sv

//--- runSim.sh
#!/usr/bin/env bash
# Compile the VGA controller testbench with Verilator and run it.
# The exit status is the simulation's own status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tbVgaController -Wno-fatal -f project.f -o simVgaController
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit "$status"
fi

./obj_dir/simVgaController
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
